// ==== filelist.f ====
design/phy_failover_pkg.sv
design/phy_status_if.sv
design/mdio_shifter.sv
design/phy_status_poller.sv
design/failover_selector.sv
design/gmii_port_steer.sv
design/phy_failover_top.sv
tb/mdio_phy_model.sv
tb/phy_failover_properties.sv
tb/phy_failover_tb.sv

// ==== Makefile ====
TOP = phy_failover_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== tb/phy_failover_tb.sv ====
`default_nettype none

module phy_failover_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MDC_DIV     = 2;
	localparam int ROUND_BOUND = 64 * 2 * MDC_DIV + 4;
	localparam int NUM_ROWS    = 7;
	localparam int CYCLE_LIMIT = NUM_ROWS * 3 * ROUND_BOUND + 200;

	typedef struct packed {
		logic [15:0] p0_status;
		logic [15:0] p1_status;
		logic [7:0]  tx_byte;
		logic [7:0]  rx_byte;
		logic        exp_link;
		logic        exp_port;
		logic [1:0]  exp_speed;
		logic        exp_duplex;
		logic        exp_up0;
		logic        exp_up1;
		logic        exp_change;
	} row_t;

	logic        clk;
	logic        reset;
	logic [1:0]  speed_o;
	logic [1:0]  phy0_speed_o;
	logic [1:0]  phy1_speed_o;
	logic        full_duplex_o;
	logic        link_up_o;
	logic        active_port_o;
	logic        link_change_o;
	logic        phy0_up_o;
	logic        phy1_up_o;
	logic [7:0]  rxd_o;
	logic [7:0]  txd_i;
	logic [7:0]  phy0_rxd_i;
	logic [7:0]  phy0_txd_o;
	logic [7:0]  phy1_rxd_i;
	logic [7:0]  phy1_txd_o;
	logic        rx_dv_o;
	logic        rx_er_o;
	logic        crs_o;
	logic        col_o;
	logic        tx_en_i;
	logic        tx_er_i;
	logic        phy0_rx_dv_i;
	logic        phy0_rx_er_i;
	logic        phy0_crs_i;
	logic        phy0_col_i;
	logic        phy0_tx_en_o;
	logic        phy0_tx_er_o;
	logic        phy1_rx_dv_i;
	logic        phy1_rx_er_i;
	logic        phy1_crs_i;
	logic        phy1_col_i;
	logic        phy1_tx_en_o;
	logic        phy1_tx_er_o;
	logic        phy0_mdc_o;
	logic        phy0_mdio_i;
	logic        phy0_mdio_o;
	logic        phy0_mdio_oe_o;
	logic        phy1_mdc_o;
	logic        phy1_mdio_i;
	logic        phy1_mdio_o;
	logic        phy1_mdio_oe_o;
	logic [15:0] phy0_status;
	logic [15:0] phy1_status;
	logic [4:0]  phy0_addr;
	logic [4:0]  phy1_addr;
	logic [31:0] lfsr;
	row_t        rows [NUM_ROWS];
	int          cycle_cnt = 0;

	phy_failover_top #(
		.PHY_ADDR(5'd1),
		.MDC_DIV (MDC_DIV)
	) dut_i (.*);

	mdio_phy_model phy0_model_i (
		.mdc_i        (phy0_mdc_o),
		.mdio_i       (phy0_mdio_o),
		.mdio_oe_i    (phy0_mdio_oe_o),
		.status_word_i(phy0_status),
		.mdio_o       (phy0_mdio_i),
		.phy_addr_o   (phy0_addr)
	);

	mdio_phy_model phy1_model_i (
		.mdc_i        (phy1_mdc_o),
		.mdio_i       (phy1_mdio_o),
		.mdio_oe_i    (phy1_mdio_oe_o),
		.status_word_i(phy1_status),
		.mdio_o       (phy1_mdio_i),
		.phy_addr_o   (phy1_addr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d clock cycles", cycle_cnt);
			$display("Simulation failed");
			$fatal(1, "Run stopped by timeout");
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_byte(output logic [7:0] b);
		b = '0;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
			$display("Simulation failed");
			$fatal(1, "Stopped at first error");
		end
	endtask

	task automatic set_row(input int i, input logic [15:0] p0, input logic [15:0] p1,
		input logic link, input logic port, input logic [1:0] speed, input logic duplex,
		input logic up0, input logic up1, input logic change);
		logic [7:0] tx;
		logic [7:0] rx;
		take_byte(tx);
		take_byte(rx);
		rows[i] = {p0, p1, tx, rx, link, port, speed, duplex, up0, up1, change};
	endtask

	// Idle PHY gets the inverted pattern so the two differ
	task automatic drive_gmii(input logic port, input logic [7:0] tx, input logic [7:0] rx);
		logic [11:0] act_pat;
		logic [11:0] idle_pat;
		act_pat  = {rx, 1'b1, rx[0], 1'b1, rx[7]};
		idle_pat = ~act_pat;
		txd_i    = tx;
		tx_en_i  = 1'b1;
		tx_er_i  = tx[0];
		{phy0_rxd_i, phy0_rx_dv_i, phy0_rx_er_i, phy0_crs_i, phy0_col_i} =
			port ? idle_pat : act_pat;
		{phy1_rxd_i, phy1_rx_dv_i, phy1_rx_er_i, phy1_crs_i, phy1_col_i} =
			port ? act_pat : idle_pat;
	endtask

	task automatic run_row(input int i);
		row_t        r;
		int          pulses;
		logic [9:0]  act_tx;
		logic [9:0]  idle_tx;
		string       tag;
		r      = rows[i];
		pulses = 0;
		tag    = $sformatf("row %0d", i);
		@(negedge clk);
		phy0_status = r.p0_status;
		phy1_status = r.p1_status;
		repeat (3 * ROUND_BOUND) begin
			@(negedge clk);
			if (link_change_o)
				pulses++;
		end
		check({tag, " link_up"}, 32'(r.exp_link), 32'(link_up_o));
		check({tag, " active_port"}, 32'(r.exp_port), 32'(active_port_o));
		check({tag, " speed"}, 32'(r.exp_speed), 32'(speed_o));
		check({tag, " full_duplex"}, 32'(r.exp_duplex), 32'(full_duplex_o));
		check({tag, " phy0_up"}, 32'(r.exp_up0), 32'(phy0_up_o));
		check({tag, " phy1_up"}, 32'(r.exp_up1), 32'(phy1_up_o));
		check({tag, " phy0_speed"}, 32'(r.p0_status[15:14]), 32'(phy0_speed_o));
		check({tag, " phy1_speed"}, 32'(r.p1_status[15:14]), 32'(phy1_speed_o));
		check({tag, " link_change pulses"}, 32'(r.exp_change), 32'(pulses));
		check({tag, " phy0 mdio address"}, 32'd1, 32'(phy0_addr));
		check({tag, " phy1 mdio address"}, 32'd1, 32'(phy1_addr));
		drive_gmii(r.exp_port, r.tx_byte, r.rx_byte);
		@(negedge clk);
		act_tx  = r.exp_port ? {phy1_txd_o, phy1_tx_en_o, phy1_tx_er_o} :
			{phy0_txd_o, phy0_tx_en_o, phy0_tx_er_o};
		idle_tx = r.exp_port ? {phy0_txd_o, phy0_tx_en_o, phy0_tx_er_o} :
			{phy1_txd_o, phy1_tx_en_o, phy1_tx_er_o};
		check({tag, " MAC receive"}, 32'({r.rx_byte, 1'b1, r.rx_byte[0], 1'b1, r.rx_byte[7]}),
			32'({rxd_o, rx_dv_o, rx_er_o, crs_o, col_o}));
		check({tag, " active transmit"}, 32'({r.tx_byte, 1'b1, r.tx_byte[0]}), 32'(act_tx));
		check({tag, " idle transmit"}, 32'd0, 32'(idle_tx));
	endtask

	initial begin
		lfsr        = 32'hcd793fa9;
		reset       = 1'b1;
		phy0_status = '0;
		phy1_status = '0;
		// GMII inputs busy while reset holds the outputs
		txd_i       = 8'hff;
		tx_en_i     = 1'b1;
		tx_er_i     = 1'b1;
		{phy0_rxd_i, phy0_rx_dv_i, phy0_rx_er_i, phy0_crs_i, phy0_col_i} = '1;
		{phy1_rxd_i, phy1_rx_dv_i, phy1_rx_er_i, phy1_crs_i, phy1_col_i} = '1;
		// Status words: speed 15:14, duplex 13, link 10
		// row, p0, p1, link, port, speed, duplex, up0, up1, change
		set_row(0, 16'h0000, 16'h6400, 1'b1, 1'b1, 2'b01, 1'b1, 1'b0, 1'b1, 1'b1);
		set_row(1, 16'h0000, 16'h6400, 1'b1, 1'b1, 2'b01, 1'b1, 1'b0, 1'b1, 1'b0);
		set_row(2, 16'ha400, 16'h6400, 1'b1, 1'b0, 2'b10, 1'b1, 1'b1, 1'b1, 1'b1);
		set_row(3, 16'h8000, 16'h6400, 1'b1, 1'b1, 2'b01, 1'b1, 1'b0, 1'b1, 1'b1);
		set_row(4, 16'h8000, 16'h4000, 1'b0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0, 1'b1);
		set_row(5, 16'h0400, 16'h0000, 1'b1, 1'b0, 2'b00, 1'b0, 1'b1, 1'b0, 1'b1);
		set_row(6, 16'h0000, 16'h0000, 1'b0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0, 1'b1);
		repeat (10) @(negedge clk);
		check("reset GMII outputs", 32'd0, {rxd_o, rx_dv_o, rx_er_o, crs_o, col_o,
			phy0_txd_o, phy0_tx_en_o, phy0_tx_er_o, phy1_txd_o, phy1_tx_en_o, phy1_tx_er_o});
		reset = 1'b0;
		repeat (2) @(negedge clk);
		// First poll round is still running here
		check("reset link_up", 32'd0, 32'(link_up_o));
		check("reset active_port", 32'd0, 32'(active_port_o));
		check("reset link_change", 32'd0, 32'(link_change_o));
		check("reset speed and duplex", 32'd0, 32'({speed_o, full_duplex_o}));
		check("reset phy0_speed", 32'd2, 32'(phy0_speed_o));
		check("reset phy1_speed", 32'd2, 32'(phy1_speed_o));
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);
		$display("Simulation passed");
		$finish;
	end
endmodule

`default_nettype wire

// ==== tb/phy_failover_properties.sv ====
`default_nettype none

module phy_failover_properties (
	input wire clk,
	input wire reset,
	input wire link_change_i,
	input wire active_port_i,
	input wire phy0_tx_en_i,
	input wire phy1_tx_en_i,
	input wire phy0_mdc_i,
	input wire phy0_mdio_oe_i,
	input wire phy1_mdc_i,
	input wire phy1_mdio_oe_i
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [6:0] rise0;
	logic [6:0] rise1;
	logic       mdc0_q;
	logic       mdc1_q;
	logic       oe0_q;
	logic       oe1_q;

	// Rising MDC edges since the frame started
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rise0  <= '0;
			rise1  <= '0;
			mdc0_q <= 1'b0;
			mdc1_q <= 1'b0;
			oe0_q  <= 1'b0;
			oe1_q  <= 1'b0;
		end else begin
			mdc0_q <= phy0_mdc_i;
			mdc1_q <= phy1_mdc_i;
			oe0_q  <= phy0_mdio_oe_i;
			oe1_q  <= phy1_mdio_oe_i;
			if (phy0_mdio_oe_i && !oe0_q)
				rise0 <= '0;
			else if (phy0_mdc_i && !mdc0_q)
				rise0 <= rise0 + 7'd1;
			if (phy1_mdio_oe_i && !oe1_q)
				rise1 <= '0;
			else if (phy1_mdc_i && !mdc1_q)
				rise1 <= rise1 + 7'd1;
		end
	end

	assert property (@(posedge clk) disable iff (reset) link_change_i |=> !link_change_i)
		else $error("link_change stayed high for two cycles");

	// Steering output lags a port change by one cycle
	assert property (@(posedge clk) disable iff (reset)
		$stable(active_port_i) |-> (active_port_i ? !phy0_tx_en_i : !phy1_tx_en_i))
		else $error("tx_en reached the idle PHY");

	assert property (@(posedge clk) disable iff (reset)
		(rise0 >= 7'd48 && rise0 <= 7'd63) |-> !phy0_mdio_oe_i)
		else $error("PHY 0 mdio_oe high during read data");

	assert property (@(posedge clk) disable iff (reset)
		(rise1 >= 7'd48 && rise1 <= 7'd63) |-> !phy1_mdio_oe_i)
		else $error("PHY 1 mdio_oe high during read data");
endmodule

bind phy_failover_top phy_failover_properties props_i (
	.clk           (clk),
	.reset         (reset),
	.link_change_i (link_change_o),
	.active_port_i (active_port_o),
	.phy0_tx_en_i  (phy0_tx_en_o),
	.phy1_tx_en_i  (phy1_tx_en_o),
	.phy0_mdc_i    (phy0_mdc_o),
	.phy0_mdio_oe_i(phy0_mdio_oe_o),
	.phy1_mdc_i    (phy1_mdc_o),
	.phy1_mdio_oe_i(phy1_mdio_oe_o)
);

`default_nettype wire

// ==== tb/mdio_phy_model.sv ====
`default_nettype none

module mdio_phy_model (
	input  wire        mdc_i,
	input  wire        mdio_i,
	input  wire        mdio_oe_i,
	input  wire [15:0] status_word_i,
	output logic       mdio_o,
	output logic [4:0] phy_addr_o
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] status_q = '0;
	logic [6:0]  rise_cnt = '0;
	logic [6:0]  rise_nxt;
	logic        oe_q     = 1'b0;
	logic        mdio_q   = 1'b1;
	logic [4:0]  addr_q   = '0;

	assign mdio_o     = mdio_q;
	assign phy_addr_o = addr_q;

	// Status word stays frozen for the whole frame
	always @(posedge mdio_oe_i)
		status_q <= status_word_i;

	// First rising MDC edge of a driven bus is edge 1
	assign rise_nxt = (mdio_oe_i && !oe_q) ? 7'd1 : rise_cnt + 7'd1;

	always @(posedge mdc_i) begin
		rise_cnt <= rise_nxt;
		oe_q     <= mdio_oe_i;
		// PHY address is frame bits 4 to 8
		if (rise_nxt >= 7'd37 && rise_nxt <= 7'd41)
			addr_q <= {addr_q[3:0], mdio_i};
	end

	// Data bit 15 is sampled on rising edge 49
	always @(negedge mdc_i) begin
		if (rise_cnt >= 7'd48 && rise_cnt <= 7'd63)
			mdio_q <= status_q[4'(7'd63 - rise_cnt)];
		else
			mdio_q <= 1'b1;
	end
endmodule

`default_nettype wire

// ==== design/phy_failover_top.sv ====
`default_nettype none

module phy_failover_top #(
	parameter logic [4:0] PHY_ADDR = 5'd0,
	parameter int         MDC_DIV  = 8
) (
	input  wire        clk,
	input  wire        reset,
	output logic [1:0] speed_o,
	output logic       full_duplex_o,
	output logic       link_up_o,
	output logic       active_port_o,
	output logic       link_change_o,
	output logic       phy0_up_o,
	output logic [1:0] phy0_speed_o,
	output logic       phy1_up_o,
	output logic [1:0] phy1_speed_o,
	// MAC side
	output logic [7:0] rxd_o,
	output logic       rx_dv_o,
	output logic       rx_er_o,
	output logic       crs_o,
	output logic       col_o,
	input  wire  [7:0] txd_i,
	input  wire        tx_en_i,
	input  wire        tx_er_i,
	// PHY 0
	input  wire  [7:0] phy0_rxd_i,
	input  wire        phy0_rx_dv_i,
	input  wire        phy0_rx_er_i,
	input  wire        phy0_crs_i,
	input  wire        phy0_col_i,
	output logic [7:0] phy0_txd_o,
	output logic       phy0_tx_en_o,
	output logic       phy0_tx_er_o,
	output logic       phy0_mdc_o,
	input  wire        phy0_mdio_i,
	output logic       phy0_mdio_o,
	output logic       phy0_mdio_oe_o,
	// PHY 1
	input  wire  [7:0] phy1_rxd_i,
	input  wire        phy1_rx_dv_i,
	input  wire        phy1_rx_er_i,
	input  wire        phy1_crs_i,
	input  wire        phy1_col_i,
	output logic [7:0] phy1_txd_o,
	output logic       phy1_tx_en_o,
	output logic       phy1_tx_er_o,
	output logic       phy1_mdc_o,
	input  wire        phy1_mdio_i,
	output logic       phy1_mdio_o,
	output logic       phy1_mdio_oe_o
);
	phy_status_if p0_stat ();
	phy_status_if p1_stat ();

	// Each PHY sits on its own MDIO bus
	phy_status_poller #(
		.PHY_ADDR(PHY_ADDR),
		.MDC_DIV (MDC_DIV)
	) poller0_i (
		.clk      (clk),
		.reset    (reset),
		.stat     (p0_stat.poller),
		.mdc_o    (phy0_mdc_o),
		.mdio_i   (phy0_mdio_i),
		.mdio_o   (phy0_mdio_o),
		.mdio_oe_o(phy0_mdio_oe_o)
	);

	phy_status_poller #(
		.PHY_ADDR(PHY_ADDR),
		.MDC_DIV (MDC_DIV)
	) poller1_i (
		.clk      (clk),
		.reset    (reset),
		.stat     (p1_stat.poller),
		.mdc_o    (phy1_mdc_o),
		.mdio_i   (phy1_mdio_i),
		.mdio_o   (phy1_mdio_o),
		.mdio_oe_o(phy1_mdio_oe_o)
	);

	failover_selector selector_i (
		.clk          (clk),
		.reset        (reset),
		.p0           (p0_stat.selector),
		.p1           (p1_stat.selector),
		.active_port_o(active_port_o),
		.link_up_o    (link_up_o),
		.speed_o      (speed_o),
		.full_duplex_o(full_duplex_o),
		.link_change_o(link_change_o),
		.phy0_up_o    (phy0_up_o),
		.phy0_speed_o (phy0_speed_o),
		.phy1_up_o    (phy1_up_o),
		.phy1_speed_o (phy1_speed_o)
	);

	// GMII port names match the top level one to one
	gmii_port_steer steer_i (
		.select_i(active_port_o),
		.*
	);
endmodule

`default_nettype wire

// ==== design/gmii_port_steer.sv ====
`default_nettype none

module gmii_port_steer (
	input  wire        clk,
	input  wire        reset,
	input  wire        select_i,
	output logic [7:0] rxd_o,
	output logic       rx_dv_o,
	output logic       rx_er_o,
	output logic       crs_o,
	output logic       col_o,
	input  wire  [7:0] txd_i,
	input  wire        tx_en_i,
	input  wire        tx_er_i,
	input  wire  [7:0] phy0_rxd_i,
	input  wire        phy0_rx_dv_i,
	input  wire        phy0_rx_er_i,
	input  wire        phy0_crs_i,
	input  wire        phy0_col_i,
	output logic [7:0] phy0_txd_o,
	output logic       phy0_tx_en_o,
	output logic       phy0_tx_er_o,
	input  wire  [7:0] phy1_rxd_i,
	input  wire        phy1_rx_dv_i,
	input  wire        phy1_rx_er_i,
	input  wire        phy1_crs_i,
	input  wire        phy1_col_i,
	output logic [7:0] phy1_txd_o,
	output logic       phy1_tx_en_o,
	output logic       phy1_tx_er_o
);
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxd_o        <= '0;
			rx_dv_o      <= 1'b0;
			rx_er_o      <= 1'b0;
			crs_o        <= 1'b0;
			col_o        <= 1'b0;
			phy0_txd_o   <= '0;
			phy0_tx_en_o <= 1'b0;
			phy0_tx_er_o <= 1'b0;
			phy1_txd_o   <= '0;
			phy1_tx_en_o <= 1'b0;
			phy1_tx_er_o <= 1'b0;
		end else begin
			rxd_o   <= select_i ? phy1_rxd_i : phy0_rxd_i;
			rx_dv_o <= select_i ? phy1_rx_dv_i : phy0_rx_dv_i;
			rx_er_o <= select_i ? phy1_rx_er_i : phy0_rx_er_i;
			crs_o   <= select_i ? phy1_crs_i : phy0_crs_i;
			col_o   <= select_i ? phy1_col_i : phy0_col_i;
			// Idle port sees an all-zero transmit side
			phy0_txd_o   <= select_i ? 8'h00 : txd_i;
			phy0_tx_en_o <= !select_i && tx_en_i;
			phy0_tx_er_o <= !select_i && tx_er_i;
			phy1_txd_o   <= select_i ? txd_i : 8'h00;
			phy1_tx_en_o <= select_i && tx_en_i;
			phy1_tx_er_o <= select_i && tx_er_i;
		end
	end
endmodule

`default_nettype wire

// ==== design/failover_selector.sv ====
`default_nettype none

module failover_selector (
	input  wire              clk,
	input  wire              reset,
	phy_status_if.selector   p0,
	phy_status_if.selector   p1,
	output logic             active_port_o,
	output logic             link_up_o,
	output logic [1:0]       speed_o,
	output logic             full_duplex_o,
	output logic             link_change_o,
	output logic             phy0_up_o,
	output logic [1:0]       phy0_speed_o,
	output logic             phy1_up_o,
	output logic [1:0]       phy1_speed_o
);
	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_POLL   = 3'd1;
	localparam logic [2:0] S_WAIT   = 3'd2;
	localparam logic [2:0] S_LATCH  = 3'd3;
	localparam logic [2:0] S_SELECT = 3'd4;

	logic [2:0] state;
	logic [2:0] state_nxt;
	logic       got0;
	logic       got1;
	logic       both_done;
	logic       phy0_duplex;
	logic       phy1_duplex;
	logic       nxt_port;
	logic       nxt_up;
	logic [1:0] nxt_speed;
	logic       nxt_duplex;

	// Both pollers start together
	assign p0.poll   = (state == S_POLL);
	assign p1.poll   = (state == S_POLL);
	assign both_done = (got0 | p0.done) & (got1 | p1.done);

	always_comb begin
		case (state)
			S_IDLE:  state_nxt = S_POLL;
			S_POLL:  state_nxt = S_WAIT;
			S_WAIT:  state_nxt = both_done ? S_LATCH : S_WAIT;
			S_LATCH: state_nxt = S_SELECT;
			default: state_nxt = S_IDLE;
		endcase
	end

	// Port 0 always wins when it is up
	always_comb begin
		nxt_up   = link_up_o;
		nxt_port = active_port_o;
		if (link_up_o) begin
			if (!phy0_up_o && !phy1_up_o) begin
				nxt_up   = 1'b0;
				nxt_port = 1'b0;
			end else if (active_port_o && phy0_up_o) begin
				nxt_port = 1'b0;
			end else if (!active_port_o && !phy0_up_o) begin
				nxt_port = 1'b1;
			end
		end else if (phy0_up_o) begin
			nxt_up   = 1'b1;
			nxt_port = 1'b0;
		end else if (phy1_up_o) begin
			nxt_up   = 1'b1;
			nxt_port = 1'b1;
		end
		if (!nxt_up) begin
			nxt_speed  = 2'b00;
			nxt_duplex = 1'b0;
		end else if (nxt_port) begin
			nxt_speed  = phy1_speed_o;
			nxt_duplex = phy1_duplex;
		end else begin
			nxt_speed  = phy0_speed_o;
			nxt_duplex = phy0_duplex;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state         <= S_IDLE;
			got0          <= 1'b0;
			got1          <= 1'b0;
			phy0_up_o     <= 1'b0;
			phy0_speed_o  <= phy_failover_pkg::SPEED_1000;
			phy0_duplex   <= 1'b1;
			phy1_up_o     <= 1'b0;
			phy1_speed_o  <= phy_failover_pkg::SPEED_1000;
			phy1_duplex   <= 1'b1;
			active_port_o <= 1'b0;
			link_up_o     <= 1'b0;
			speed_o       <= 2'b00;
			full_duplex_o <= 1'b0;
			link_change_o <= 1'b0;
		end else begin
			state         <= state_nxt;
			link_change_o <= 1'b0;
			if (state == S_POLL) begin
				got0 <= 1'b0;
				got1 <= 1'b0;
			end else begin
				if (p0.done)
					got0 <= 1'b1;
				if (p1.done)
					got1 <= 1'b1;
			end
			if (state == S_LATCH) begin
				phy0_up_o    <= p0.link_up;
				phy0_speed_o <= p0.speed;
				phy0_duplex  <= p0.duplex;
				phy1_up_o    <= p1.link_up;
				phy1_speed_o <= p1.speed;
				phy1_duplex  <= p1.duplex;
			end
			if (state == S_SELECT) begin
				active_port_o <= nxt_port;
				link_up_o     <= nxt_up;
				speed_o       <= nxt_speed;
				full_duplex_o <= nxt_duplex;
				link_change_o <= (nxt_port != active_port_o) || (nxt_up != link_up_o) ||
					(nxt_speed != speed_o) || (nxt_duplex != full_duplex_o);
			end
		end
	end
endmodule

`default_nettype wire

// ==== design/phy_status_poller.sv ====
`default_nettype none

module phy_status_poller #(
	parameter logic [4:0] PHY_ADDR = 5'd0,
	parameter int         MDC_DIV  = 2
) (
	input  wire                 clk,
	input  wire                 reset,
	phy_status_if.poller        stat,
	output logic                mdc_o,
	input  wire                 mdio_i,
	output logic                mdio_o,
	output logic                mdio_oe_o
);
	phy_failover_pkg::mdio_frame_t frame;
	logic [15:0]                   rd_data;
	logic                          sh_done;

	// Read of the status register, data slot left at zero
	always_comb begin
		frame.fields.start      = phy_failover_pkg::MDIO_START;
		frame.fields.op         = phy_failover_pkg::MDIO_OP_READ;
		frame.fields.phy_addr   = PHY_ADDR;
		frame.fields.reg_addr   = phy_failover_pkg::STATUS_REG;
		frame.fields.turnaround = phy_failover_pkg::MDIO_TA;
		frame.fields.data       = '0;
	end

	mdio_shifter #(
		.MDC_DIV(MDC_DIV)
	) shifter_i (
		.clk      (clk),
		.reset    (reset),
		.start_i  (stat.poll),
		.frame_i  (frame),
		.mdc_o    (mdc_o),
		.mdio_i   (mdio_i),
		.mdio_o   (mdio_o),
		.mdio_oe_o(mdio_oe_o),
		.rd_data_o(rd_data),
		.done_o   (sh_done)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stat.done    <= 1'b0;
			stat.link_up <= 1'b0;
			stat.speed   <= phy_failover_pkg::SPEED_1000;
			stat.duplex  <= 1'b1;
		end else begin
			stat.done <= sh_done;
			// Decode once per completed read
			if (sh_done) begin
				stat.link_up <= rd_data[phy_failover_pkg::STAT_LINK_BIT];
				stat.duplex  <= rd_data[phy_failover_pkg::STAT_DUPLEX_BIT];
				stat.speed   <= rd_data[phy_failover_pkg::STAT_SPEED_MSB -: 2];
			end
		end
	end
endmodule

`default_nettype wire

// ==== design/mdio_shifter.sv ====
`default_nettype none

module mdio_shifter #(
	parameter int MDC_DIV = 2
) (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           start_i,
	input  phy_failover_pkg::mdio_frame_t frame_i,
	output logic                          mdc_o,
	input  wire                           mdio_i,
	output logic                          mdio_o,
	output logic                          mdio_oe_o,
	output logic [15:0]                   rd_data_o,
	output logic                          done_o
);
	localparam int DIV_W = $clog2(MDC_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_MAX = DIV_W'(MDC_DIV - 1);

	// Bit positions counted from the first preamble bit
	localparam logic [5:0] FRAME_FIRST = 6'(phy_failover_pkg::PREAMBLE_LEN);
	localparam logic [5:0] OE_END      = 6'(phy_failover_pkg::PREAMBLE_LEN + 14);
	localparam logic [5:0] DATA_FIRST  = 6'(phy_failover_pkg::PREAMBLE_LEN + 16);
	localparam logic [5:0] LAST_BIT    = 6'(phy_failover_pkg::PREAMBLE_LEN + 31);

	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	logic [5:0]       bit_cnt;
	logic [5:0]       bit_nxt;
	logic [31:0]      tx_sr;
	logic             tick;
	logic             rise;
	logic             fall;

	assign tick    = busy && (div_cnt == DIV_MAX);
	assign rise    = tick && !mdc_o;
	assign fall    = tick && mdc_o;
	assign bit_nxt = bit_cnt + 6'd1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy      <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			mdc_o     <= 1'b0;
			mdio_o    <= 1'b1;
			mdio_oe_o <= 1'b0;
			done_o    <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (!busy) begin
				if (start_i) begin
					busy      <= 1'b1;
					div_cnt   <= '0;
					bit_cnt   <= '0;
					mdc_o     <= 1'b0;
					mdio_o    <= 1'b1;
					mdio_oe_o <= 1'b1;
				end
			end else if (tick) begin
				div_cnt <= '0;
				mdc_o   <= !mdc_o;
				// Output bits move on the falling edge
				if (mdc_o) begin
					if (bit_cnt == LAST_BIT) begin
						busy   <= 1'b0;
						done_o <= 1'b1;
						mdio_o <= 1'b1;
					end else begin
						bit_cnt   <= bit_nxt;
						mdio_oe_o <= (bit_nxt < OE_END);
						if (bit_nxt >= FRAME_FIRST)
							mdio_o <= tx_sr[31];
					end
				end
			end else begin
				div_cnt <= div_cnt + DIV_W'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start_i)
			tx_sr <= frame_i.raw;
		else if (fall && bit_nxt >= FRAME_FIRST)
			tx_sr <= {tx_sr[30:0], 1'b0};
		// Read data sampled on rising MDC
		if (rise && bit_cnt >= DATA_FIRST)
			rd_data_o <= {rd_data_o[14:0], mdio_i};
	end
endmodule

`default_nettype wire

// ==== design/phy_status_if.sv ====
`default_nettype none

interface phy_status_if;
	logic       poll;
	logic       done;
	logic       link_up;
	logic [1:0] speed;
	logic       duplex;

	modport poller (
		input  poll,
		output done,
		output link_up,
		output speed,
		output duplex
	);

	modport selector (
		output poll,
		input  done,
		input  link_up,
		input  speed,
		input  duplex
	);
endinterface

`default_nettype wire

// ==== design/phy_failover_pkg.sv ====
`default_nettype none

package phy_failover_pkg;

	// One MDIO management frame, sent MSB first
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [1:0]  start;
			logic [1:0]  op;
			logic [4:0]  phy_addr;
			logic [4:0]  reg_addr;
			logic [1:0]  turnaround;
			logic [15:0] data;
		} fields;
	} mdio_frame_t;

	localparam logic [1:0] MDIO_START   = 2'b01;
	localparam logic [1:0] MDIO_OP_READ = 2'b10;
	localparam logic [1:0] MDIO_TA      = 2'b10;

	// PHY specific status register
	localparam logic [4:0] STATUS_REG = 5'd17;

	localparam logic [1:0] SPEED_10   = 2'b00;
	localparam logic [1:0] SPEED_100  = 2'b01;
	localparam logic [1:0] SPEED_1000 = 2'b10;

	// Bit positions in the status word, speed is 15:14
	localparam int STAT_LINK_BIT   = 10;
	localparam int STAT_DUPLEX_BIT = 13;
	localparam int STAT_SPEED_MSB  = 15;

	// MDC cycles of ones ahead of each frame
	localparam int PREAMBLE_LEN = 32;

endpackage

`default_nettype wire
